// File: verilog/color_proc_pkg.sv
// pixel format, filter codes, colour limits and width types of the colour processor
`default_nettype none

package color_proc_pkg;

  // one colour channel of an rgb444 pixel
  typedef logic [3:0] chan_t;

  // rgb444 pixel, red in the top nibble, blue in the bottom one
  typedef logic [11:0] pixel_t;

  // linear pixel address, 15 bits cover qqvga (160x120 = 19200)
  typedef logic [14:0] pix_addr_t;

  // column or row index
  typedef logic [7:0] coord_t;

  // one histogram bin or the frame total, max 13312 for qqvga
  typedef logic [13:0] hist_cnt_t;

  // filter codes, one bit per primary in {red, green, blue} order
  typedef enum logic [2:0] {
    filt_none = 3'b000, // every pixel passes
    filt_red  = 3'b100,
    filt_grn  = 3'b010,
    filt_blu  = 3'b001,
    filt_yel  = 3'b110, // red + green
    filt_mag  = 3'b101, // red + blue
    filt_cya  = 3'b011, // green + blue
    filt_whi  = 3'b111  // bright gray
  } filter_e;

  // two channels are similar up to this absolute difference
  localparam chan_t simil_limit = 4'd2;

  // two channels are very different from this absolute difference on
  localparam chan_t vdif_limit = 4'd4;

  // every channel of a white pixel reaches at least this value
  localparam chan_t white_min = 4'd12;

  // value written for a pixel that misses the filter
  localparam pixel_t black_pxl = 12'h000;

endpackage

`default_nettype wire

// File: verilog/frame_ctrl.sv
// frame sequencer FSM: idle, pixel scan, two-cycle pipeline flush and result publish
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic new_frame_i, // one-cycle strobe from the capture side
  input  logic last_pxl_i,  // last address is on the read bus
  output logic scan_o,      // counter runs
  output logic publish_o    // histogram snapshot strobe
);

  typedef enum logic [2:0] {
    idle,
    scan,
    flush1,  // last pixel data back from memory
    flush2,  // last hit reaches the histogram
    publish
  } state_e;

  state_e state, state_nxt;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) state <= idle;
    else     state <= state_nxt;
  end

  // frame start is only taken in idle, no handshake back to the capture side
  always_comb begin
    state_nxt = state;
    case (state)
      idle:    if (new_frame_i) state_nxt = scan;
      scan:    if (last_pxl_i) state_nxt = flush1;
      flush1:  state_nxt = flush2;
      flush2:  state_nxt = publish;
      publish: state_nxt = idle;
      default: state_nxt = idle;
    endcase
  end

  assign scan_o    = (state == scan);
  assign publish_o = (state == publish); // single cycle, state always moves on

endmodule

`default_nettype wire

// File: verilog/pixel_scan_counter.sv
// raster scan counter: read address, column and row, inner-frame and histogram bin decode
`timescale 1ns/1ps
`default_nettype none

module pixel_scan_counter #(
  parameter int img_cols    = 160,
  parameter int img_rows    = 120,
  parameter int border_cols = 16,
  parameter int border_rows = 8,
  parameter int hist_bins   = 8,
  localparam int bin_w      = $clog2(hist_bins)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     scan_i,
  output logic                     last_pxl_o,
  output color_proc_pkg::pix_addr_t orig_addr_o, // to the source image memory
  output logic                     pix_valid_o,  // aligned with the memory data
  output color_proc_pkg::pix_addr_t pix_addr_o,
  output logic                     in_frame_o,
  output logic [bin_w-1:0]         bin_o
);

  import color_proc_pkg::*;

  localparam pix_addr_t last_addr = pix_addr_t'(img_cols * img_rows - 1);
  localparam coord_t    last_col  = coord_t'(img_cols - 1);
  localparam int        bin_cols  = (img_cols - 2 * border_cols) / hist_bins; // columns per bin

  pix_addr_t          addr;
  coord_t             col, row;
  coord_t             col_inner; // column counted from the left inner edge
  logic               in_frame;
  logic [bin_w-1:0]   bin;

  assign last_pxl_o  = scan_i && (addr == last_addr);
  assign orig_addr_o = addr;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      addr <= '0;
      col  <= '0;
      row  <= '0;
    end else if (!scan_i || last_pxl_o) begin // park at zero between frames
      addr <= '0;
      col  <= '0;
      row  <= '0;
    end else begin
      addr <= addr + 1'b1;
      if (col == last_col) begin // end of line
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // inner frame is the image minus the border on every side
  assign in_frame = (col >= border_cols) && (col < img_cols - border_cols) &&
                    (row >= border_rows) && (row < img_rows - border_rows);

  // garbage outside the inner frame, never counted there
  assign col_inner = col - coord_t'(border_cols);
  assign bin       = bin_w'(col_inner / coord_t'(bin_cols));

  // one stage so the decodes meet the pixel from the 1-cycle read
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pix_valid_o <= 1'b0;
      in_frame_o  <= 1'b0;
    end else begin
      pix_valid_o <= scan_i;
      in_frame_o  <= in_frame;
    end
  end

  always_ff @(posedge clk) begin
    pix_addr_o <= addr;
    bin_o      <= bin;
  end

endmodule

`default_nettype wire

// File: verilog/color_classifier.sv
// pixel colour classifier, filter select and processed-pixel write stage
`timescale 1ns/1ps
`default_nettype none

module color_classifier #(
  parameter int hist_bins = 8,
  localparam int bin_w    = $clog2(hist_bins)
) (
  input  logic                      clk,
  input  logic                      rst,
  input  color_proc_pkg::filter_e   filter_i,
  input  color_proc_pkg::pixel_t    orig_pxl_i,  // from source memory
  input  logic                      pix_valid_i,
  input  color_proc_pkg::pix_addr_t pix_addr_i,
  input  logic                      in_frame_i,
  input  logic [bin_w-1:0]          bin_i,
  output logic                      proc_we_o,
  output color_proc_pkg::pix_addr_t proc_addr_o,
  output color_proc_pkg::pixel_t    proc_pxl_o,  // original or black
  output logic                      hit_o,
  output logic                      count_en_o,  // valid pixel inside the inner frame
  output logic [bin_w-1:0]          hit_bin_o
);

  import color_proc_pkg::*;

  chan_t   red, grn, blu;
  chan_t   top, mid, low;        // channels sorted by value
  filter_e top_id, mid_id;       // one-hot primary of top and mid
  chan_t   dif_tm, dif_tl, dif_ml;
  logic    is_gray, is_white;
  filter_e color_class;          // filt_none when gray or no colour
  logic    hit_d;
  pixel_t  pxl_q;

  assign red = orig_pxl_i[11:8];
  assign grn = orig_pxl_i[7:4];
  assign blu = orig_pxl_i[3:0];

  // sort, on a tie blue ranks above green, green above red
  always_comb begin
    if (blu >= grn && blu >= red) begin
      top    = blu;
      top_id = filt_blu;
      if (grn >= red) begin
        mid    = grn;
        mid_id = filt_grn;
        low    = red;
      end else begin
        mid    = red;
        mid_id = filt_red;
        low    = grn;
      end
    end else if (grn >= red) begin // here green is strictly above blue
      top    = grn;
      top_id = filt_grn;
      if (blu >= red) begin
        mid    = blu;
        mid_id = filt_blu;
        low    = red;
      end else begin
        mid    = red;
        mid_id = filt_red;
        low    = blu;
      end
    end else begin // red strictly above both
      top    = red;
      top_id = filt_red;
      if (blu >= grn) begin
        mid    = blu;
        mid_id = filt_blu;
        low    = grn;
      end else begin
        mid    = grn;
        mid_id = filt_grn;
        low    = blu;
      end
    end
  end

  // sorted, so no absolute value needed
  assign dif_tm = top - mid;
  assign dif_tl = top - low;
  assign dif_ml = mid - low;

  always_comb begin
    color_class = filt_none;
    is_gray     = 1'b0;
    if (dif_tm >= vdif_limit) begin
      color_class = top_id;                       // pure primary
    end else if (dif_tm <= simil_limit) begin
      if (dif_tl <= simil_limit)
        is_gray = 1'b1;
      else if (dif_ml >= vdif_limit)
        color_class = filter_e'(top_id | mid_id); // one-hot or gives the mix code
    end
  end

  assign is_white = is_gray && (red >= white_min) && (grn >= white_min) && (blu >= white_min);

  always_comb begin
    case (filter_i)
      filt_none: hit_d = 1'b1;
      filt_whi:  hit_d = is_white;
      default:   hit_d = (color_class == filter_i);
    endcase
  end

  // output stage, write and histogram strobes
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      proc_we_o  <= 1'b0;
      count_en_o <= 1'b0;
      hit_o      <= 1'b0;
    end else begin
      proc_we_o  <= pix_valid_i;
      count_en_o <= pix_valid_i && in_frame_i;
      hit_o      <= hit_d;
    end
  end

  always_ff @(posedge clk) begin
    proc_addr_o <= pix_addr_i;
    pxl_q       <= orig_pxl_i;
    hit_bin_o   <= bin_i;
  end

  assign proc_pxl_o = hit_o ? pxl_q : black_pxl;

endmodule

`default_nettype wire

// File: verilog/histogram_accum.sv
// spatial histogram: running bin and total counters with end-of-frame snapshot
`timescale 1ns/1ps
`default_nettype none

module histogram_accum #(
  parameter int hist_bins = 8,
  localparam int bin_w    = $clog2(hist_bins)
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       hit_i,
  input  logic                                       count_en_i,
  input  logic [bin_w-1:0]                           bin_i,
  input  logic                                       publish_i,
  output color_proc_pkg::hist_cnt_t [hist_bins-1:0] hist_o,       // bin 0 is leftmost
  output color_proc_pkg::hist_cnt_t                  colorpxls_o,  // hits in the inner frame
  output logic                                       new_frame_proc_o
);

  import color_proc_pkg::*;

  hist_cnt_t [hist_bins-1:0] run_hist;  // counts of the frame in progress
  hist_cnt_t                 run_total;
  logic                      count_hit;

  assign count_hit = count_en_i && hit_i;

  // running counts, cleared once they have been copied out
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      run_hist  <= '0;
      run_total <= '0;
    end else if (publish_i) begin
      run_hist  <= '0;
      run_total <= '0;
    end else if (count_hit) begin
      run_hist[bin_i] <= run_hist[bin_i] + 1'b1;
      run_total       <= run_total + 1'b1;
    end
  end

  // published results hold until the next frame ends
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      hist_o           <= '0;
      colorpxls_o      <= '0;
      new_frame_proc_o <= 1'b0;
    end else begin
      new_frame_proc_o <= publish_i; // one cycle, publish is a single-cycle state
      if (publish_i) begin
        hist_o      <= run_hist;
        colorpxls_o <= run_total;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/color_proc.sv
// colour processor top: sequencer, scan counter, classifier and histogram
`timescale 1ns/1ps
`default_nettype none

module color_proc #(
  parameter int img_cols    = 160,
  parameter int img_rows    = 120,
  parameter int border_cols = 16, // removed on each side
  parameter int border_rows = 8,
  parameter int hist_bins   = 8
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       new_frame_i,
  input  color_proc_pkg::filter_e                    filter_i,
  input  color_proc_pkg::pixel_t                     orig_pxl_i,
  output color_proc_pkg::pix_addr_t                  orig_addr_o,
  output logic                                       proc_we_o,
  output color_proc_pkg::pix_addr_t                  proc_addr_o,
  output color_proc_pkg::pixel_t                     proc_pxl_o,
  output color_proc_pkg::hist_cnt_t [hist_bins-1:0] hist_o,
  output color_proc_pkg::hist_cnt_t                  colorpxls_o,
  output logic                                       new_frame_proc_o
);

  import color_proc_pkg::*;

  localparam int bin_w = $clog2(hist_bins);

  logic             scan, publish, last_pxl;
  logic             pix_valid, in_frame;  // aligned with orig_pxl_i
  pix_addr_t        pix_addr;
  logic [bin_w-1:0] pix_bin;
  logic             hit, count_en;        // aligned with the write
  logic [bin_w-1:0] hit_bin;

  frame_ctrl i_frame_ctrl (
    .clk         (clk),
    .rst         (rst),
    .new_frame_i (new_frame_i),
    .last_pxl_i  (last_pxl),
    .scan_o      (scan),
    .publish_o   (publish)
  );

  pixel_scan_counter #(
    .img_cols    (img_cols),
    .img_rows    (img_rows),
    .border_cols (border_cols),
    .border_rows (border_rows),
    .hist_bins   (hist_bins)
  ) i_pixel_scan_counter (
    .clk         (clk),
    .rst         (rst),
    .scan_i      (scan),
    .last_pxl_o  (last_pxl),
    .orig_addr_o (orig_addr_o),
    .pix_valid_o (pix_valid),
    .pix_addr_o  (pix_addr),
    .in_frame_o  (in_frame),
    .bin_o       (pix_bin)
  );

  color_classifier #(
    .hist_bins (hist_bins)
  ) i_color_classifier (
    .clk         (clk),
    .rst         (rst),
    .filter_i    (filter_i),
    .orig_pxl_i  (orig_pxl_i),
    .pix_valid_i (pix_valid),
    .pix_addr_i  (pix_addr),
    .in_frame_i  (in_frame),
    .bin_i       (pix_bin),
    .proc_we_o   (proc_we_o),
    .proc_addr_o (proc_addr_o),
    .proc_pxl_o  (proc_pxl_o),
    .hit_o       (hit),
    .count_en_o  (count_en),
    .hit_bin_o   (hit_bin)
  );

  histogram_accum #(
    .hist_bins (hist_bins)
  ) i_histogram_accum (
    .clk              (clk),
    .rst              (rst),
    .hit_i            (hit),
    .count_en_i       (count_en),
    .bin_i            (hit_bin),
    .publish_i        (publish),
    .hist_o           (hist_o),
    .colorpxls_o      (colorpxls_o),
    .new_frame_proc_o (new_frame_proc_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_color_proc.sv
// testbench for the colour processor with image memories, reference model and random frames
`timescale 1ns/1ps
`default_nettype none

module tb_color_proc;

  import color_proc_pkg::*;

  localparam int img_cols    = 48;
  localparam int img_rows    = 16;
  localparam int border_cols = 8;
  localparam int border_rows = 2;
  localparam int hist_bins   = 8;
  localparam int npix        = img_cols * img_rows;
  localparam int bin_cols    = (img_cols - 2 * border_cols) / hist_bins; // 4 columns per bin
  localparam int inner_rows  = img_rows - 2 * border_rows;

  logic                      clk = 1'b0;
  logic                      rst, new_frame_i;
  filter_e                   filter_i;
  pixel_t                    orig_pxl_i, proc_pxl_o;
  pix_addr_t                 orig_addr_o, proc_addr_o;
  logic                      proc_we_o, new_frame_proc_o;
  hist_cnt_t [hist_bins-1:0] hist_o;
  hist_cnt_t                 colorpxls_o;

  pixel_t    src_img [npix];  // source memory contents
  pixel_t    res_img [npix];  // what the DUT wrote
  int        wr_cnt  [npix];  // writes seen per address
  pixel_t    exp_img [npix];
  hist_cnt_t exp_hist [hist_bins];
  hist_cnt_t exp_total;
  int        model_hits;      // hits over the whole image including the border
  pix_addr_t rd_addr;         // address held for the 1-cycle read
  int        writes, pulses, seed;
  string     test_name;
  filter_e   colour_codes [7] = '{filt_red, filt_grn, filt_blu, filt_yel,
                                  filt_mag, filt_cya, filt_whi};

  color_proc #(
    .img_cols    (img_cols),
    .img_rows    (img_rows),
    .border_cols (border_cols),
    .border_rows (border_rows),
    .hist_bins   (hist_bins)
  ) i_color_proc (
    .clk              (clk),
    .rst              (rst),
    .new_frame_i      (new_frame_i),
    .filter_i         (filter_i),
    .orig_pxl_i       (orig_pxl_i),
    .orig_addr_o      (orig_addr_o),
    .proc_we_o        (proc_we_o),
    .proc_addr_o      (proc_addr_o),
    .proc_pxl_o       (proc_pxl_o),
    .hist_o           (hist_o),
    .colorpxls_o      (colorpxls_o),
    .new_frame_proc_o (new_frame_proc_o)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation aborted at first error");
  endtask

  task automatic check_pixel(input string what, input pixel_t exp, input pixel_t act);
    if (exp !== act) begin
      $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string what, input hist_cnt_t exp, input hist_cnt_t act);
    if (exp !== act) begin
      $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  // source memory answers one cycle later with data changing on the falling edge
  always @(negedge clk) begin
    orig_pxl_i = src_img[rd_addr];
    rd_addr    = orig_addr_o;
  end

  // result memory sampled mid-cycle where the outputs are settled
  always @(negedge clk) begin
    if (proc_we_o) begin
      if (proc_addr_o >= npix) begin
        $display("write to address %0d outside the image", proc_addr_o);
        abort_run();
      end
      res_img[proc_addr_o] = proc_pxl_o;
      wr_cnt[proc_addr_o]++;
      writes++;
    end
    if (new_frame_proc_o)
      pulses++;
  end

  // pixel classification by channel order with white as bright gray
  function automatic bit model_hit(input pixel_t p, input filter_e f);
    int         v [3];
    int         t, m, l;
    logic [2:0] cls;
    bit         gray;
    v[0] = p[11:8]; // red
    v[1] = p[7:4];
    v[2] = p[3:0];
    t = 0;
    l = 0;
    for (int i = 1; i < 3; i++) begin
      if (v[i] >= v[t]) t = i; // higher index wins a tie at the top
      if (v[i] < v[l]) l = i;  // lower index stays lowest on a tie
    end
    m    = 3 - t - l;
    cls  = 3'b000;
    gray = 1'b0;
    if (v[t] - v[m] >= vdif_limit)
      cls = 3'b100 >> t;
    else if (v[t] - v[m] <= simil_limit) begin
      if (v[t] - v[l] <= simil_limit)
        gray = 1'b1;
      else if (v[m] - v[l] >= vdif_limit)
        cls = (3'b100 >> t) | (3'b100 >> m);
    end
    if (f == filt_none) return 1'b1;
    if (f == filt_whi)
      return gray && v[0] >= white_min && v[1] >= white_min && v[2] >= white_min;
    return cls == f;
  endfunction

  // expected processed image, bins and total for one frame
  task automatic model_frame(input filter_e f);
    int col;
    int row;
    bit h;
    exp_total  = '0;
    model_hits = 0;
    for (int b = 0; b < hist_bins; b++)
      exp_hist[b] = '0;
    for (int a = 0; a < npix; a++) begin
      col        = a % img_cols;
      row        = a / img_cols;
      h          = model_hit(src_img[a], f);
      exp_img[a] = h ? src_img[a] : 12'h000;
      model_hits += int'(h);
      if (h && col >= border_cols && col < img_cols - border_cols &&
          row >= border_rows && row < img_rows - border_rows) begin
        exp_hist[(col - border_cols) / bin_cols]++;
        exp_total++;
      end
    end
  endtask

  // biased mode spreads pixels over pure, mix, gray and white classes
  task automatic fill_image(input bit biased);
    logic [31:0] r;
    chan_t       c [3];
    int          ch;
    for (int a = 0; a < npix; a++) begin
      r    = $random(seed);
      c[0] = {2'b00, r[9:8]};   // dark channels
      c[1] = {2'b00, r[23:22]};
      c[2] = {2'b00, r[25:24]};
      ch   = r[11:10] % 3;
      case (biased ? r[14:12] : 3'd7)
        3'd0, 3'd1: c[ch] = 4'hc | {2'b00, r[5:4]}; // pure primary
        3'd2, 3'd3: begin
          c[ch]           = 4'hc | {2'b00, r[5:4]};
          c[(ch + 1) % 3] = c[ch];                  // two-colour mix
        end
        3'd4: begin
          c[0] = r[19:16]; // gray and sometimes bright enough for white
          c[1] = c[0];
          c[2] = c[0];
        end
        3'd5: begin
          c[0] = 4'hc | {2'b00, r[5:4]};
          c[1] = c[0];
          c[2] = c[0];
        end
        default: begin
          c[0] = r[31:28];
          c[1] = r[27:24];
          c[2] = r[19:16];
        end
      endcase
      src_img[a] = {c[0], c[1], c[2]};
    end
  endtask

  // one frame from start strobe to published counts with an optional stray start mid-scan
  task automatic run_frame(input filter_e f, input bit extra_start);
    int cyc;
    int writes_done;
    for (int a = 0; a < npix; a++) begin
      wr_cnt[a]  = 0;
      res_img[a] = '0;
    end
    writes = 0;
    pulses = 0;
    model_frame(f);
    filter_i    = f;
    new_frame_i = 1'b1;
    @(negedge clk);
    new_frame_i = 1'b0;
    cyc         = 0;
    while (!new_frame_proc_o) begin
      @(negedge clk);
      cyc++;
      new_frame_i = extra_start && (cyc == 100); // lands well inside the scan
      if (cyc > 2 * npix) begin
        $display("timeout, no new_frame_proc_o within %0d cycles", cyc);
        abort_run();
      end
    end
    @(negedge clk);
    check_bit("result pulse width", 1'b0, new_frame_proc_o);
    for (int b = 0; b < hist_bins; b++)
      check_count($sformatf("bin %0d", b), exp_hist[b], hist_o[b]);
    check_count("total", exp_total, colorpxls_o);
    for (int a = 0; a < npix; a++) begin
      check_bit($sformatf("address %0d written once", a), 1'b1, wr_cnt[a] == 1);
      check_pixel($sformatf("pixel %0d", a), exp_img[a], res_img[a]);
    end
    writes_done = writes;
    repeat (50) @(negedge clk);
    check_bit("no writes after the frame", 1'b1, writes == writes_done);
    check_bit("single result pulse", 1'b1, pulses == 1);
  endtask

  initial begin
    seed        = 83964;
    rst         = 1'b1;
    new_frame_i = 1'b0;
    filter_i    = filt_none;
    orig_pxl_i  = '0;
    rd_addr     = '0;
    writes      = 0;
    pulses      = 0;
    test_name   = "reset";
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_bit("proc_we_o", 1'b0, proc_we_o);
    check_bit("new_frame_proc_o", 1'b0, new_frame_proc_o);
    check_count("total", '0, colorpxls_o);
    for (int b = 0; b < hist_bins; b++)
      check_count($sformatf("bin %0d", b), '0, hist_o[b]);

    // pass-through frame where every inner pixel counts
    test_name = "no filter";
    fill_image(1'b0);
    run_frame(filt_none, 1'b0);
    for (int b = 0; b < hist_bins; b++)
      check_count($sformatf("full bin %0d", b), hist_cnt_t'(inner_rows * bin_cols), hist_o[b]);
    check_count("full total", hist_cnt_t'(inner_rows * (img_cols - 2 * border_cols)),
                colorpxls_o);

    for (int i = 0; i < 7; i++) begin
      test_name = $sformatf("filter %s", colour_codes[i].name());
      fill_image(1'b1);
      model_frame(colour_codes[i]);
      check_bit("class present in image", 1'b1, model_hits > 0);
      run_frame(colour_codes[i], 1'b0);
    end

    test_name = "start during scan";
    fill_image(1'b1);
    run_frame(filt_cya, 1'b1);

    // back to back frames where the counts show the second frame alone
    test_name = "first of two";
    fill_image(1'b0);
    run_frame(filt_none, 1'b0);
    test_name = "second of two";
    fill_image(1'b1);
    run_frame(filt_red, 1'b0);

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
verilog/color_proc_pkg.sv
verilog/frame_ctrl.sv
verilog/pixel_scan_counter.sv
verilog/color_classifier.sv
verilog/histogram_accum.sv
verilog/color_proc.sv
tests/tb_color_proc.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_color_proc
	./obj_dir/Vtb_color_proc | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
